// File: src/lpRegPkg.sv
// APB register map of the LP20 controller; 5-bit offsets, 16-bit full-word access only
package lpRegPkg;

   //////////////////////////////////////////////////
   // Widths

   localparam int regWidth   = 16;       // Register and APB data width
   localparam int paddrWidth = 5;        // APB offset width

   //////////////////////////////////////////////////
   // Register offsets

   typedef enum logic [paddrWidth-1:0]
   {
      regCsra = 5'h00,                   // Control and status
      regBar  = 5'h04,                   // Bus address, low 16 bits
      regBctr = 5'h08,                   // Byte counter, counts up to zero
      regCctr = 5'h0C,                   // CCTR high byte, CBUF low byte
      regCksm = 5'h10                    // CKSM high byte, PDAT low byte
   } lpReg;

   //////////////////////////////////////////////////
   // CSRA bit positions

   localparam logic [3:0] csraGo     = 4'd0;    // Write starts a block, reads busy
   localparam logic [3:0] csraIe     = 4'd6;    // Interrupt enable
   localparam logic [3:0] csraDone   = 4'd7;
   localparam logic [3:0] csraOnline = 4'd11;   // Printer online input
   localparam logic [3:0] csraEclr   = 4'd14;   // Write only

   // Any error
   localparam logic [3:0] csraErr    = 4'd15;

   // Error causes
   localparam logic [3:0] errGo      = 4'd12;   // GO with byte counter at zero
   localparam logic [3:0] errMem     = 4'd13;   // Memory error on a fetch

endpackage

// File: src/lpPrintPkg.sv
// Transfer state encoding and printer character constants; 8-bit characters without translation
package lpPrintPkg;

   localparam int charWidth = 8;

   //////////////////////////////////////////////////
   // Transfer states

   typedef enum logic [1:0]
   {
      stIdle,                            // Waiting for GO
      stFetch,                           // Memory read outstanding
      stPrint,                           // Waiting for printer strobe
      stFinish                           // Set DONE
   } lpState;

   //////////////////////////////////////////////////
   // Characters that reset the column counter

   localparam logic [charWidth-1:0] chLf = 8'h0A;
   localparam logic [charWidth-1:0] chFf = 8'h0C;
   localparam logic [charWidth-1:0] chCr = 8'h0D;

endpackage

// File: src/lpRegFile.sv
// APB without wait states, full 16-bit writes only; GO is ignored while a block is running
module lpRegFile #(
   parameter int ADDR_WIDTH = 18
)(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic [lpRegPkg::paddrWidth-1:0] paddr,
   input  logic [lpRegPkg::regWidth-1:0]   pwdata,
   output logic [lpRegPkg::regWidth-1:0]   prdata,
   output logic                            pready,
   output logic                            pslverr,
   input  logic                            lpOnline,
   input  logic                            busy,
   input  logic                            setDone,
   input  logic                            setGoErr,
   input  logic                            setMemErr,
   input  logic [ADDR_WIDTH-1:0]           bar,
   input  logic [lpRegPkg::regWidth-1:0]   bctr,
   input  logic [lpPrintPkg::charWidth-1:0] cctr,
   input  logic [lpPrintPkg::charWidth-1:0] lastChar,
   input  logic [lpPrintPkg::charWidth-1:0] cksm,
   input  logic [lpPrintPkg::charWidth-1:0] pdat,
   output logic                            cmdGo,
   output logic                            barWrite,
   output logic                            bctrWrite,
   output logic [lpRegPkg::regWidth-1:0]   wrData,
   output logic                            irq
);

   lpRegPkg::lpReg                  regSel;
   logic                            accWr;
   logic                            wrCsra;
   logic                            eclr;
   logic                            ie, done, err, errGoFlag, errMemFlag;
   logic [lpRegPkg::regWidth-1:0]   csraVal;

   assign regSel    = lpRegPkg::lpReg'(paddr);
   assign accWr     = psel & penable & pwrite;       // Access phase write
   assign wrCsra    = accWr && (regSel == lpRegPkg::regCsra);
   assign cmdGo     = wrCsra & pwdata[lpRegPkg::csraGo] & ~busy;
   assign eclr      = wrCsra & pwdata[lpRegPkg::csraEclr];
   assign barWrite  = accWr && (regSel == lpRegPkg::regBar);
   assign bctrWrite = accWr && (regSel == lpRegPkg::regBctr);
   assign wrData    = pwdata;
   assign pready    = 1'b1;
   assign pslverr   = 1'b0;
   assign irq       = ie & done;

   //////////////////////////////////////////////////
   // CSRA flags with block status winning over software clears

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ie         <= 1'b0;
         done       <= 1'b0;
         err        <= 1'b0;
         errGoFlag  <= 1'b0;
         errMemFlag <= 1'b0;
      end
      else
      begin
         if (wrCsra)
            ie <= pwdata[lpRegPkg::csraIe];
         if (cmdGo || eclr)
         begin
            done       <= 1'b0;
            errGoFlag  <= 1'b0;
            errMemFlag <= 1'b0;
         end
         if (eclr)
            err <= 1'b0;                             // ERR stays until ECLR
         if (setGoErr)
         begin
            err       <= 1'b1;
            errGoFlag <= 1'b1;
         end
         if (setMemErr)
         begin
            err        <= 1'b1;
            errMemFlag <= 1'b1;
         end
         if (setDone)
            done <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Read-back

   always_comb
   begin
      csraVal                         = '0;
      csraVal[lpRegPkg::csraGo]     = busy;
      csraVal[lpRegPkg::csraIe]     = ie;
      csraVal[lpRegPkg::csraDone]   = done;
      csraVal[lpRegPkg::csraOnline] = lpOnline;
      csraVal[lpRegPkg::errGo]      = errGoFlag;
      csraVal[lpRegPkg::errMem]     = errMemFlag;
      csraVal[lpRegPkg::csraErr]    = err;
      prdata                          = '0;
      if (psel && penable && !pwrite)
      begin
         case (regSel)
            lpRegPkg::regCsra: prdata = csraVal;
            lpRegPkg::regBar:  prdata = bar[lpRegPkg::regWidth-1:0];
            lpRegPkg::regBctr: prdata = bctr;
            lpRegPkg::regCctr: prdata = {cctr, lastChar};
            lpRegPkg::regCksm: prdata = {cksm, pdat};
            default:           prdata = '0;         // Unmapped
         endcase
      end
   end

   // A GO that is taken always leads to a running block or to DONE
   assert property (@(posedge clk) disable iff (rst) cmdGo |-> !busy ##1 (busy || done))
      else $error("GO accepted while busy or without effect");

endmodule

// File: src/lpDmaEngine.sv
// Byte-wide memory reads at BAR; BCTR holds minus the remaining count, BAR writes are zero extended
module lpDmaEngine #(
   parameter int ADDR_WIDTH = 18
)(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             barWrite,
   input  logic                             bctrWrite,
   input  logic [lpRegPkg::regWidth-1:0]    wrData,
   input  logic                             cmdGo,
   input  logic                             startFetch,
   output logic                             memReq,
   output logic [ADDR_WIDTH-1:0]            memAddr,
   input  logic                             memAck,
   input  logic [lpPrintPkg::charWidth-1:0] memData,
   input  logic                             memErr,
   output logic [ADDR_WIDTH-1:0]            bar,
   output logic [lpRegPkg::regWidth-1:0]    bctr,
   output logic                             bctrZero,
   output logic                             fetchDone,
   output logic                             memErrSeen,
   output logic [lpPrintPkg::charWidth-1:0] fetchByte,
   output logic [lpPrintPkg::charWidth-1:0] cksm
);

   logic goodAck;

   assign memAddr    = bar;
   assign bctrZero   = (bctr == '0);
   assign fetchDone  = memReq & memAck;              // Ack cycle
   assign memErrSeen = fetchDone & memErr;
   assign goodAck    = fetchDone & ~memErr;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         memReq    <= 1'b0;
         bar       <= '0;
         bctr      <= '0;
         cksm      <= '0;
         fetchByte <= '0;
      end
      else
      begin
         if (startFetch)
            memReq <= 1'b1;
         else if (memAck)
            memReq <= 1'b0;                          // Drops the cycle after ack
         if (barWrite)
            bar <= ADDR_WIDTH'(wrData);
         else if (goodAck)
            bar <= bar + 1'b1;
         if (bctrWrite)
            bctr <= wrData;
         else if (goodAck)
            bctr <= bctr + 1'b1;                     // Counts up towards zero
         if (cmdGo)
            cksm <= '0;
         else if (goodAck)
            cksm <= cksm + memData;                  // Sum mod 256
         if (goodAck)
            fetchByte <= memData;
      end
   end

   // Request holds its address until acknowledged
   assert property (@(posedge clk) disable iff (rst)
      memReq && !memAck |=> memReq && $stable(memAddr))
      else $error("memory request dropped or address moved before ack");

endmodule

// File: src/lpPrinterPort.sv
// Printer side with demand/strobe handshake and odd parity; one byte in flight at a time
module lpPrinterPort (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             cmdGo,
   input  logic                             startPrint,
   input  logic [lpPrintPkg::charWidth-1:0] fetchByte,
   input  logic                             lpDemand,
   output logic [lpPrintPkg::charWidth-1:0] lpData,
   output logic                             lpDpar,
   output logic                             lpStrobe,
   output logic                             printDone,
   output logic [lpPrintPkg::charWidth-1:0] cctr,
   output logic [lpPrintPkg::charWidth-1:0] pdat
);

   logic loadPend;                                   // Byte lands in fetchByte this cycle
   logic pending;                                    // Byte waiting for demand
   logic lineCtl;

   assign lpStrobe  = pending & lpDemand;
   assign printDone = lpStrobe;
   assign lineCtl   = (lpData == lpPrintPkg::chLf) || (lpData == lpPrintPkg::chFf)
                      || (lpData == lpPrintPkg::chCr);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         loadPend <= 1'b0;
         pending  <= 1'b0;
         cctr     <= '0;
         pdat     <= '0;
      end
      else
      begin
         loadPend <= startPrint;
         if (loadPend)
            pending <= 1'b1;
         else if (lpStrobe)
            pending <= 1'b0;
         if (cmdGo)
            cctr <= '0;
         else if (lpStrobe)
            cctr <= lineCtl ? '0 : cctr + 1'b1;      // Wraps at 256
         if (lpStrobe)
            pdat <= lpData;
      end
   end

   // Output byte and parity
   always_ff @(posedge clk)
   begin
      if (loadPend)
      begin
         lpData <= fetchByte;
         lpDpar <= ~^fetchByte;                      // Odd ones over data and parity
      end
   end

   // Strobe only on demand, and never two in a row
   assert property (@(posedge clk) disable iff (rst) lpStrobe |-> lpDemand ##1 !lpStrobe)
      else $error("strobe without demand or longer than one cycle");

endmodule

// File: src/lpControl.sv
// Block sequencer; one byte is fetched and printed before the next fetch starts
module lpControl (
   input  logic clk,
   input  logic rst,
   input  logic cmdGo,
   input  logic bctrZero,
   input  logic fetchDone,
   input  logic memErrSeen,
   input  logic printDone,
   output logic startFetch,
   output logic startPrint,
   output logic busy,
   output logic setDone,
   output logic setGoErr,
   output logic setMemErr
);

   lpPrintPkg::lpState state, nextState;

   assign busy = (state != lpPrintPkg::stIdle);

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= lpPrintPkg::stIdle;
      else
         state <= nextState;
   end

   //////////////////////////////////////////////////
   // Next state and pulses

   always_comb
   begin
      nextState  = state;
      startFetch = 1'b0;
      startPrint = 1'b0;
      setDone    = 1'b0;
      setGoErr   = 1'b0;
      setMemErr  = 1'b0;
      case (state)
         lpPrintPkg::stIdle:
            if (cmdGo && bctrZero)
            begin
               setGoErr = 1'b1;                      // Nothing to print
               setDone  = 1'b1;
            end
            else if (cmdGo)
            begin
               startFetch = 1'b1;
               nextState  = lpPrintPkg::stFetch;
            end
         lpPrintPkg::stFetch:
            if (memErrSeen)
            begin
               setMemErr = 1'b1;                     // Byte is dropped
               nextState = lpPrintPkg::stFinish;
            end
            else if (fetchDone)
            begin
               startPrint = 1'b1;
               nextState  = lpPrintPkg::stPrint;
            end
         lpPrintPkg::stPrint:
            if (printDone && bctrZero)
               nextState = lpPrintPkg::stFinish;     // Counter already advanced
            else if (printDone)
            begin
               startFetch = 1'b1;
               nextState  = lpPrintPkg::stFetch;
            end
         default:
         begin
            setDone   = 1'b1;
            nextState = lpPrintPkg::stIdle;
         end
      endcase
   end

   // Print starts from a fetch and never overlaps a printer strobe
   assert property (@(posedge clk) disable iff (rst)
      startPrint |-> (state == lpPrintPkg::stFetch) && !printDone)
      else $error("print started outside fetch or over a running print");

endmodule

// File: src/lp20.sv
// LP20 style printer controller top; ADDR_WIDTH of at least 16, BAR reads its low 16 bits
module lp20 #(
   parameter int ADDR_WIDTH = 18
)(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             psel,
   input  logic                             penable,
   input  logic                             pwrite,
   input  logic [lpRegPkg::paddrWidth-1:0]  paddr,
   input  logic [lpRegPkg::regWidth-1:0]    pwdata,
   output logic [lpRegPkg::regWidth-1:0]    prdata,
   output logic                             pready,
   output logic                             pslverr,
   output logic                             memReq,
   output logic [ADDR_WIDTH-1:0]            memAddr,
   input  logic                             memAck,
   input  logic [lpPrintPkg::charWidth-1:0] memData,
   input  logic                             memErr,
   output logic [lpPrintPkg::charWidth-1:0] lpData,
   output logic                             lpDpar,
   output logic                             lpStrobe,
   input  logic                             lpDemand,
   input  logic                             lpOnline,
   output logic                             irq
);

   logic                             cmdGo, barWrite, bctrWrite;
   logic [lpRegPkg::regWidth-1:0]    wrData, bctr;
   logic [ADDR_WIDTH-1:0]            bar;
   logic                             bctrZero, fetchDone, memErrSeen, printDone;
   logic                             startFetch, startPrint, busy;
   logic                             setDone, setGoErr, setMemErr;
   logic [lpPrintPkg::charWidth-1:0] fetchByte, cksm, cctr, pdat;

   lpRegFile #(.ADDR_WIDTH(ADDR_WIDTH)) regFile (
      .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
      .lpOnline, .busy, .setDone, .setGoErr, .setMemErr, .bar, .bctr, .cctr,
      .lastChar(fetchByte), .cksm, .pdat, .cmdGo, .barWrite, .bctrWrite, .wrData, .irq
   );

   lpControl control (
      .clk, .rst, .cmdGo, .bctrZero, .fetchDone, .memErrSeen, .printDone,
      .startFetch, .startPrint, .busy, .setDone, .setGoErr, .setMemErr
   );

   lpDmaEngine #(.ADDR_WIDTH(ADDR_WIDTH)) dmaEngine (
      .clk, .rst, .barWrite, .bctrWrite, .wrData, .cmdGo, .startFetch, .memReq, .memAddr,
      .memAck, .memData, .memErr, .bar, .bctr, .bctrZero, .fetchDone, .memErrSeen,
      .fetchByte, .cksm
   );

   lpPrinterPort printerPort (
      .clk, .rst, .cmdGo, .startPrint, .fetchByte, .lpDemand, .lpData, .lpDpar,
      .lpStrobe, .printDone, .cctr, .pdat
   );

endmodule

// File: dv/lpDevModels.sv
// Memory with an address-derived fill and random ack latency, printer with random demand; no real timing
module lpMemory #(
   parameter int ADDR_WIDTH = 18,
   parameter int SEED       = 1
)(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             slow,       // Random ack latency when high
   input  logic                             errEn,
   input  logic [ADDR_WIDTH-1:0]            errAddr,
   input  logic                             memReq,
   input  logic [ADDR_WIDTH-1:0]            memAddr,
   output logic                             memAck,
   output logic [lpPrintPkg::charWidth-1:0] memData,
   output logic                             memErr
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [lpPrintPkg::charWidth-1:0] mem [0:(1<<ADDR_WIDTH)-1];
   integer                           seed;
   int                               waitCnt;

   initial
   begin
      for (int i = 0; i < (1 << ADDR_WIDTH); i++)
         mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 16);  // Every address bit counts
      seed    = SEED;
      waitCnt = 0;
      memAck  = 1'b0;
      memData = '0;
      memErr  = 1'b0;
      forever
      begin
         @(posedge clk);
         #2;
         memAck  = 1'b0;                             // Ack lasts one cycle
         memData = '0;
         memErr  = 1'b0;
         if (!rst && memReq)
         begin
            if (waitCnt > 0)
               waitCnt = waitCnt - 1;
            else
            begin
               memAck  = 1'b1;
               memData = mem[memAddr];
               memErr  = errEn && (memAddr == errAddr);
               waitCnt = slow ? int'({$random(seed)} % 5) : 0;
            end
         end
      end
   end

endmodule

module lpPrinter #(
   parameter int SEED = 1
)(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             slow,       // Random demand gaps when high
   input  logic [lpPrintPkg::charWidth-1:0] lpData,
   input  logic                             lpDpar,
   input  logic                             lpStrobe,
   output logic                             lpDemand,
   output logic                             lpOnline
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [lpPrintPkg::charWidth-1:0] rxData [0:1023];
   logic                             rxPar [0:1023];
   int                               rxCount = 0;
   integer                           seed;

   assign lpOnline = 1'b1;

   initial
   begin
      seed     = SEED;
      lpDemand = 1'b0;
      forever
      begin
         @(posedge clk);
         #2;
         if (rst)
            lpDemand = 1'b0;
         else if (slow)
            lpDemand = ({$random(seed)} % 2) == 0;
         else
            lpDemand = 1'b1;
      end
   end

   // Strobe is settled mid-cycle
   always @(negedge clk)
   begin
      if (!rst && lpStrobe)
      begin
         rxData[rxCount] <= lpData;
         rxPar[rxCount]  <= lpDpar;
         rxCount         <= rxCount + 1;
      end
   end

endmodule

// File: dv/lpTb.sv
// Directed tests of lp20 over APB; runs stop at the first mismatch, printed bytes stay below 1024
module lpTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          addrWidth = 18;
   localparam int          clkPeriod = 40;
   localparam int          numTests  = 5;
   localparam int          seedBase  = 32'h6351_838b;
   localparam logic [15:0] goBit     = 16'h1 << lpRegPkg::csraGo;
   localparam logic [15:0] ieBit     = 16'h1 << lpRegPkg::csraIe;
   localparam logic [15:0] doneBit   = 16'h1 << lpRegPkg::csraDone;
   localparam logic [15:0] onlineBit = 16'h1 << lpRegPkg::csraOnline;
   localparam logic [15:0] eclrBit   = 16'h1 << lpRegPkg::csraEclr;
   localparam logic [15:0] errBit    = 16'h1 << lpRegPkg::csraErr;
   localparam logic [15:0] goErrBit  = 16'h1 << lpRegPkg::errGo;
   localparam logic [15:0] memErrBit = 16'h1 << lpRegPkg::errMem;

   logic                             clk = 1'b0;
   logic                             rst;
   logic                             psel, penable, pwrite;
   logic [lpRegPkg::paddrWidth-1:0]  paddr;
   logic [lpRegPkg::regWidth-1:0]    pwdata, prdata;
   logic                             pready, pslverr;
   logic                             memReq, memAck, memErr;
   logic [addrWidth-1:0]             memAddr, errAddr;
   logic [lpPrintPkg::charWidth-1:0] memData, lpData;
   logic                             lpDpar, lpStrobe, lpDemand, lpOnline, irq;
   logic                             slowMode, errEn;

   lp20 #(.ADDR_WIDTH(addrWidth)) i_dut (.*);

   lpMemory #(.ADDR_WIDTH(addrWidth), .SEED(seedBase)) memModel (
      .clk, .rst, .slow(slowMode), .errEn, .errAddr, .memReq, .memAddr,
      .memAck, .memData, .memErr
   );

   lpPrinter #(.SEED(seedBase + 1)) printer (
      .clk, .rst, .slow(slowMode), .lpData, .lpDpar, .lpStrobe, .lpDemand, .lpOnline
   );

   always #(clkPeriod / 2) clk = ~clk;

   //////////////////////////////////////////////////
   // Failure handling and compares

   task automatic abortRun();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic checkReg(input logic [lpRegPkg::regWidth-1:0] got, exp, input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         abortRun();
      end
   endtask

   task automatic checkChar(input logic [lpPrintPkg::charWidth-1:0] got, exp,
                            input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         abortRun();
      end
   endtask

   task automatic checkFlag(input logic got, exp, input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
         abortRun();
      end
   endtask

   //////////////////////////////////////////////////
   // APB access tasks that start 2 ns after a rising edge

   task automatic apbWrite(input lpRegPkg::lpReg addr, input logic [15:0] data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #2 penable = 1'b1;
      @(posedge clk);                                // Write lands here
      #2;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apbRead(input lpRegPkg::lpReg addr, output logic [15:0] data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge clk);
      #2 penable = 1'b1;
      @(negedge clk);
      data = prdata;
      @(posedge clk);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic waitDone(input int maxPolls);
      logic [15:0] csra;
      int          polls;
      polls = 0;
      apbRead(lpRegPkg::regCsra, csra);
      while (!csra[lpRegPkg::csraDone] && polls < maxPolls)
      begin
         polls++;
         apbRead(lpRegPkg::regCsra, csra);
      end
      if (!csra[lpRegPkg::csraDone])
      begin
         $display("The block never finished: DONE stayed low after %0d polls", maxPolls);
         abortRun();
      end
   endtask

   // Program a block of n bytes and wait for DONE
   task automatic runBlock(input int start, input int n, input logic [15:0] extra);
      apbWrite(lpRegPkg::regBar, 16'(start));
      apbWrite(lpRegPkg::regBctr, 16'(-n));          // Two's complement of the length
      apbWrite(lpRegPkg::regCsra, goBit | extra);
      waitDone(3000);
   endtask

   task automatic checkPrinted(input int first, input int start, input int n);
      checkReg(16'(printer.rxCount - first), 16'(n), "printed byte count");
      for (int i = 0; i < n; i++)
      begin
         checkChar(printer.rxData[first + i], memModel.mem[start + i], "printed byte");
         checkFlag(^{printer.rxData[first + i], printer.rxPar[first + i]}, 1'b1, "odd parity");
      end
   endtask

   task automatic checkSums(input int start, input int n);
      logic [7:0]  sum, col, b;
      logic [15:0] v;
      sum = '0;
      col = '0;
      b   = '0;
      for (int i = 0; i < n; i++)
      begin
         b   = memModel.mem[start + i];
         sum = sum + b;
         if (b == lpPrintPkg::chLf || b == lpPrintPkg::chFf || b == lpPrintPkg::chCr)
            col = '0;                                // Line control restarts the column
         else
            col = col + 8'd1;
      end
      apbRead(lpRegPkg::regCksm, v);
      checkChar(v[15:8], sum, "CKSM");
      checkChar(v[7:0], b, "PDAT");
      apbRead(lpRegPkg::regCctr, v);
      checkChar(v[15:8], col, "CCTR");
      checkChar(v[7:0], b, "CBUF");
   endtask

   //////////////////////////////////////////////////
   // Directed tests

   task automatic testResetRegs();
      logic [15:0] v;
      checkFlag(memReq, 1'b0, "memReq after reset");
      checkFlag(lpStrobe, 1'b0, "lpStrobe after reset");
      checkFlag(irq, 1'b0, "irq after reset");
      checkFlag(pready, 1'b1, "pready");
      checkFlag(pslverr, 1'b0, "pslverr");
      apbRead(lpRegPkg::regCsra, v);
      checkReg(v, onlineBit, "CSRA after reset");
      apbRead(lpRegPkg::regBar, v);
      checkReg(v, 16'h0000, "BAR after reset");
      apbRead(lpRegPkg::regBctr, v);
      checkReg(v, 16'h0000, "BCTR after reset");
      apbRead(lpRegPkg::regCctr, v);
      checkReg(v, 16'h0000, "CCTR after reset");
      apbRead(lpRegPkg::regCksm, v);
      checkReg(v, 16'h0000, "CKSM after reset");
      apbWrite(lpRegPkg::regBar, 16'hA5C3);
      apbWrite(lpRegPkg::regBctr, 16'h5A3C);
      apbRead(lpRegPkg::regBar, v);
      checkReg(v, 16'hA5C3, "BAR read back");
      apbRead(lpRegPkg::regBctr, v);
      checkReg(v, 16'h5A3C, "BCTR read back");
      apbRead(lpRegPkg::lpReg'(5'h14), v);
      checkReg(v, 16'h0000, "unmapped offset");
   endtask

   task automatic testBlockPrint();
      logic [15:0] v;
      int          first;
      first = printer.rxCount;
      runBlock(16'h1234, 16, 16'h0);
      checkPrinted(first, 16'h1234, 16);
      apbRead(lpRegPkg::regCsra, v);
      checkReg(v, onlineBit | doneBit, "CSRA after block");
      apbRead(lpRegPkg::regBctr, v);
      checkReg(v, 16'h0000, "BCTR after block");
      apbRead(lpRegPkg::regBar, v);
      checkReg(v, 16'h1244, "BAR after block");
   endtask

   task automatic testChecksum();
      runBlock(16'h0100, 24, 16'h0);                 // Holds LF, CR and FF
      checkSums(16'h0100, 24);
   endtask

   task automatic testBackPressure();
      logic [15:0] v;
      int          first;
      first    = printer.rxCount;
      slowMode = 1'b1;
      runBlock(16'h02F3, 40, 16'h0);
      slowMode = 1'b0;
      checkPrinted(first, 16'h02F3, 40);
      checkSums(16'h02F3, 40);
      apbRead(lpRegPkg::regBar, v);
      checkReg(v, 16'h031B, "BAR after slow block");
      apbRead(lpRegPkg::regBctr, v);
      checkReg(v, 16'h0000, "BCTR after slow block");
   endtask

   task automatic testIrqErrors();
      logic [15:0] v;
      int          first;
      runBlock(16'h0500, 4, ieBit);
      checkFlag(irq, 1'b1, "irq after completion");
      apbWrite(lpRegPkg::regBctr, 16'(-2));
      apbWrite(lpRegPkg::regCsra, goBit | ieBit);
      checkFlag(irq, 1'b0, "irq after GO write");
      waitDone(3000);
      checkFlag(irq, 1'b1, "irq after second block");
      apbWrite(lpRegPkg::regCsra, 16'h0000);
      checkFlag(irq, 1'b0, "irq with IE cleared");

      // GO with the counter already at zero
      first = printer.rxCount;
      apbWrite(lpRegPkg::regCsra, goBit);
      checkFlag(memReq, 1'b0, "memReq after GO error");
      apbRead(lpRegPkg::regCsra, v);
      checkReg(v, onlineBit | doneBit | goErrBit | errBit, "CSRA after GO error");
      apbWrite(lpRegPkg::regCsra, eclrBit);
      apbRead(lpRegPkg::regCsra, v);
      checkReg(v, onlineBit, "CSRA after ECLR");
      checkReg(16'(printer.rxCount - first), 16'h0000, "strobes after GO error");

      // Fourth fetch fails
      first   = printer.rxCount;
      errAddr = addrWidth'(16'h0603);
      errEn   = 1'b1;
      runBlock(16'h0600, 8, 16'h0);
      errEn   = 1'b0;
      checkPrinted(first, 16'h0600, 3);
      apbRead(lpRegPkg::regCsra, v);
      checkReg(v, onlineBit | doneBit | memErrBit | errBit, "CSRA after memory error");
      apbRead(lpRegPkg::regBctr, v);
      checkReg(v, 16'hFFFB, "BCTR after memory error");
      apbRead(lpRegPkg::regBar, v);
      checkReg(v, 16'h0603, "BAR after memory error");
      apbWrite(lpRegPkg::regCsra, eclrBit);
      apbRead(lpRegPkg::regCsra, v);
      checkReg(v, onlineBit, "CSRA after second ECLR");
   endtask

   //////////////////////////////////////////////////
   // Sequence and watchdog

   initial
   begin
      rst      = 1'b1;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      slowMode = 1'b0;
      errEn    = 1'b0;
      errAddr  = '0;
      repeat (2) @(posedge clk);
      #2 rst = 1'b0;
      testResetRegs();
      testBlockPrint();
      testChecksum();
      testBackPressure();
      testIrqErrors();
      $display("Result: PASSED");
      $finish;
   end

   initial
   begin
      #(numTests * 4000 * clkPeriod);
      $display("The run timed out after %0d clock cycles", numTests * 4000);
      abortRun();
   end

endmodule

// File: sim.f
src/lpRegPkg.sv
src/lpPrintPkg.sv
src/lpRegFile.sv
src/lpDmaEngine.sv
src/lpPrinterPort.sv
src/lpControl.sv
src/lp20.sv
dv/lpDevModels.sv
dv/lpTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the LP20 testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module lpTb -f sim.f -o lpSim

# The run may stop with a nonzero status, the log decides
./obj_dir/lpSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
   echo "run.sh: simulation passed"
else
   echo "run.sh: simulation failed"
   exit 1
fi
